// ==== flist.f ====
verilog/l1_cache_pkg.sv
verilog/cache_line_array.sv
verilog/cache_controller.sv
verilog/line_fill_engine.sv
verilog/flush_engine.sv
verilog/mem_bus_arbiter.sv
verilog/l1_cache_top.sv
test/l1_cache_properties.sv
test/tb_l1_cache.sv

// ==== test/l1_cache_properties.sv ====
/*
 * l1 cache bus properties
 * memory bus rules, the flush_done pulse and the init walk after reset
 */
`timescale 1ns/1ps

module l1_cache_properties (
    input logic                   CLK,
    input logic                   nRST,
    input l1_cache_pkg::cpu_rsp_t cpu_rsp,
    input logic                   flush_done,
    input l1_cache_pkg::mem_req_t mem_req,
    input l1_cache_pkg::mem_rsp_t mem_rsp
);

    // cycles since reset release, saturates at N_SETS
    int unsigned init_cnt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            init_cnt <= 0;
        end else if (init_cnt < l1_cache_pkg::N_SETS) begin
            init_cnt <= init_cnt + 1;
        end
    end

    // one direction per word
    a_no_rd_wr: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else $error("memory read and write requested in the same cycle");

    // back-pressure freezes the request
    a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req))
        else $error("memory request changed while the bus was busy");

    a_flush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else $error("flush_done held for more than one cycle");

    // init walk clears one line per cycle
    a_init_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (init_cnt < l1_cache_pkg::N_SETS) |-> cpu_rsp.busy)
        else $error("cpu bus not busy during the init walk");

endmodule

bind l1_cache_top l1_cache_properties props_i (
    .CLK, .nRST, .cpu_rsp, .flush_done, .mem_req, .mem_rsp
);

// ==== test/tb_l1_cache.sv ====
/*
 * l1 data cache testbench
 * word memory model with random back-pressure, a shadow memory for
 * expected data, and a table of reads, writes, flushes and memory checks
 */
`timescale 1ns/1ps

module tb_l1_cache;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 500;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_FLUSH, OP_MEM} op_kind_t;

    typedef struct packed {
        op_kind_t            kind;
        l1_cache_pkg::word_t addr;
        l1_cache_pkg::word_t data;
        logic [3:0]          be;
    } op_t;

    logic                   CLK;
    logic                   nRST;
    l1_cache_pkg::cpu_req_t cpu_req;
    l1_cache_pkg::cpu_rsp_t cpu_rsp;
    logic                   flush;
    logic                   flush_done;
    l1_cache_pkg::mem_req_t mem_req;
    l1_cache_pkg::mem_rsp_t mem_rsp;
    logic                   mem_busy;

    l1_cache_pkg::word_t mem    [MEM_WORDS];
    l1_cache_pkg::word_t shadow [MEM_WORDS];
    op_t                 ops [$];
    string               names [$];
    integer              seed = 32'h078a99d8;
    int                  n_checks;
    int                  n_errors;
    int                  n_timeouts;

    l1_cache_top l1_cache_top_i (
        .CLK, .nRST, .cpu_req, .cpu_rsp, .flush, .flush_done, .mem_req, .mem_rsp
    );

    always #5 CLK = ~CLK;

    // 1 KB window, word addressed
    assign mem_rsp = {mem_busy, mem[mem_req.addr[9:2]]};

    always @(posedge CLK) begin
        if (mem_req.wen && !mem_busy) begin
            mem[mem_req.addr[9:2]] <= mem_req.wdata;
        end
    end

    // busy on about a third of cycles
    always @(negedge CLK) begin
        mem_busy <= (({$random(seed)} % 3) == 0);
    end

    function automatic l1_cache_pkg::word_t merge_bytes(
        input l1_cache_pkg::word_t old_w,
        input l1_cache_pkg::word_t new_w,
        input logic [3:0]          be
    );
        l1_cache_pkg::word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_value(input string name, input l1_cache_pkg::word_t expected,
                               input l1_cache_pkg::word_t actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic add_op(input op_kind_t op_kind, input l1_cache_pkg::word_t op_addr,
                          input l1_cache_pkg::word_t op_data, input logic [3:0] op_be,
                          input string name);
        ops.push_back('{kind: op_kind, addr: op_addr, data: op_data, be: op_be});
        names.push_back(name);
    endtask

    // hold one request until busy falls, sampled after the falling edge
    task automatic cpu_access(input op_t op, input string name,
                              output l1_cache_pkg::word_t rdata);
        int n;
        cpu_req.ren     = (op.kind == OP_RD);
        cpu_req.wen     = (op.kind == OP_WR);
        cpu_req.addr    = op.addr;
        cpu_req.wdata   = op.data;
        cpu_req.byte_en = op.be;
        n = 0;
        #1;
        while (cpu_rsp.busy && n < TIMEOUT) begin
            @(negedge CLK);
            #1;
            n++;
        end
        if (cpu_rsp.busy) begin
            n_timeouts++;
            $display("ERROR: %s got no answer from the cache in %0d cycles", name, TIMEOUT);
        end
        rdata = cpu_rsp.rdata;
        @(negedge CLK);
        cpu_req.ren = 1'b0;
        cpu_req.wen = 1'b0;
    endtask

    task automatic run_flush(input string name);
        int n;
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        n = 0;
        #1;
        while (!flush_done && n < TIMEOUT) begin
            @(negedge CLK);
            #1;
            n++;
        end
        if (!flush_done) begin
            n_timeouts++;
            $display("ERROR: %s saw no flush_done in %0d cycles", name, TIMEOUT);
        end
        // last writeback lands on the edge that ends the walk
        @(negedge CLK);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("%s word %0d", name, i), shadow[i], mem[i]);
        end
    endtask

    // whole line in memory against the shadow
    task automatic check_line(input l1_cache_pkg::word_t addr, input string name);
        int base;
        base = int'(addr[9:4]) * l1_cache_pkg::BLOCK_WORDS;
        for (int w = 0; w < l1_cache_pkg::BLOCK_WORDS; w++) begin
            check_value($sformatf("%s word %0d", name, w), shadow[base + w], mem[base + w]);
        end
    endtask

    task automatic build_table();
        // first touch of set 0 misses and fetches the initial line
        add_op(OP_RD, 32'h000, '0, 4'h0, "first_read");
        add_op(OP_RD, 32'h008, '0, 4'h0, "same_line_hit");
        add_op(OP_WR, 32'h004, 32'ha5a5a5a5, 4'b0001, "write_byte0");
        add_op(OP_RD, 32'h004, '0, 4'h0, "read_byte0");
        add_op(OP_WR, 32'h004, 32'h11223344, 4'b0100, "write_byte2");
        add_op(OP_RD, 32'h004, '0, 4'h0, "read_byte2");
        add_op(OP_WR, 32'h00c, 32'hdeadbeef, 4'b1100, "write_half_hi");
        add_op(OP_WR, 32'h008, 32'hcafef00d, 4'b0011, "write_half_lo");
        add_op(OP_WR, 32'h000, 32'h01234567, 4'b1111, "write_full");
        add_op(OP_RD, 32'h00c, '0, 4'h0, "read_half_hi");
        add_op(OP_RD, 32'h008, '0, 4'h0, "read_half_lo");
        // same set, other tag, so the dirty line goes back
        add_op(OP_RD, 32'h104, '0, 4'h0, "evict_read");
        add_op(OP_MEM, 32'h000, '0, 4'h0, "evict_writeback");
        add_op(OP_RD, 32'h004, '0, 4'h0, "reread_old");
        // dirty lines over several sets
        add_op(OP_WR, 32'h010, 32'h0badcafe, 4'b1111, "write_set1");
        add_op(OP_WR, 32'h2f4, 32'h76543210, 4'b0110, "write_set15");
        add_op(OP_WR, 32'h3a8, 32'hfeedface, 4'b1000, "write_set10");
        add_op(OP_WR, 32'h05c, 32'h13579bdf, 4'b0101, "write_set5");
        add_op(OP_FLUSH, '0, '0, 4'h0, "flush_all");
        add_op(OP_RD, 32'h2f4, '0, 4'h0, "read_after_flush_set15");
        add_op(OP_RD, 32'h010, '0, 4'h0, "read_after_flush_set1");
        add_op(OP_RD, 32'h004, '0, 4'h0, "read_after_flush_set0");
        // tag 2 line made dirty, then pushed out by tag 0
        add_op(OP_WR, 32'h204, 32'h89abcdef, 4'b1001, "write_tag2");
        add_op(OP_RD, 32'h000, '0, 4'h0, "evict_tag2");
        add_op(OP_MEM, 32'h200, '0, 4'h0, "tag2_writeback");
        add_op(OP_FLUSH, '0, '0, 4'h0, "final_flush");
    endtask

    task automatic run_table(input l1_cache_pkg::word_t data_mask);
        l1_cache_pkg::word_t rdata;
        int                  idx;
        op_t                 op;
        for (int i = 0; i < ops.size(); i++) begin
            op      = ops[i];
            op.data = op.data ^ data_mask;
            idx     = int'(op.addr[9:2]);
            case (op.kind)
                OP_RD: begin
                    cpu_access(op, names[i], rdata);
                    check_value(names[i], shadow[idx], rdata);
                end
                OP_WR: begin
                    cpu_access(op, names[i], rdata);
                    shadow[idx] = merge_bytes(shadow[idx], op.data, op.be);
                end
                OP_FLUSH: begin
                    run_flush(names[i]);
                end
                default: begin
                    check_line(op.addr, names[i]);
                end
            endcase
        end
    endtask

    initial begin
        CLK        = 1'b0;
        nRST       = 1'b0;
        flush      = 1'b0;
        cpu_req    = '0;
        mem_busy   = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = $random(seed);
            shadow[i] = mem[i];
        end
        build_table();
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        // table ends in a flush, so pass two starts from an empty cache
        run_table('0);
        // inverted write data on pass two, so its writebacks change memory
        run_table('1);
        $display("checks %0d, mismatches %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/cache_controller.sv ====
/*
 * cache controller
 * tag lookup and same-cycle hit response, byte merge on write hits,
 * miss hand-off to the fill engine, refill write and init/flush sequencing
 */
`timescale 1ns/1ps

module cache_controller (
    input  logic                           CLK,
    input  logic                           nRST,
    input  l1_cache_pkg::cpu_req_t         cpu_req,
    output l1_cache_pkg::cpu_rsp_t         cpu_rsp,
    input  logic                           flush,
    output logic                           flush_done,
    output logic [l1_cache_pkg::SET_W-1:0] rd_set,
    input  l1_cache_pkg::cache_line_t      rd_line,
    output logic                           wr_en,
    output l1_cache_pkg::cache_line_t      wr_line,
    output logic                           fill_start,
    output l1_cache_pkg::fill_cmd_t        fill_cmd,
    input  logic                           fill_done,
    input  l1_cache_pkg::line_data_t       fill_line,
    output logic                           flush_start,
    output logic                           init_mode,
    input  logic                           walk_done
);

    typedef enum logic [2:0] {
        ST_INIT, ST_LOOKUP, ST_MISS_WAIT, ST_REFILL, ST_FLUSH
    } state_t;

    state_t state_q, state_d;
    logic   flush_pend_q;
    logic   hit;
    logic   access;

    l1_cache_pkg::cache_addr_u req_a;
    l1_cache_pkg::cache_addr_u victim_a;
    l1_cache_pkg::cache_addr_u fetch_a;

    assign req_a.raw = cpu_req.addr;
    assign rd_set    = req_a.f.set;
    assign access    = cpu_req.ren | cpu_req.wen;
    assign hit       = rd_line.valid && (rd_line.tag == req_a.f.tag);

    // line bases for the victim and the new line
    always_comb begin
        victim_a            = '0;
        victim_a.f.tag      = rd_line.tag;
        victim_a.f.set      = req_a.f.set;
        fetch_a             = req_a;
        fetch_a.f.word      = '0;
        fetch_a.f.byte_off  = '0;
    end

    assign fill_cmd.victim_dirty = rd_line.valid & rd_line.dirty;
    assign fill_cmd.victim_base  = victim_a.raw;
    assign fill_cmd.victim_data  = rd_line.data;
    assign fill_cmd.fetch_base   = fetch_a.raw;

    // read data comes straight off the array
    assign cpu_rsp.rdata = rd_line.data[req_a.f.word];

    always_comb begin
        state_d      = state_q;
        cpu_rsp.busy = 1'b1;
        wr_en        = 1'b0;
        wr_line      = rd_line;
        fill_start   = 1'b0;
        flush_start  = 1'b0;
        init_mode    = 1'b0;
        flush_done   = 1'b0;
        case (state_q)
            ST_INIT: begin
                // clear every line, nothing written back
                flush_start = 1'b1;
                init_mode   = 1'b1;
                if (walk_done) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (flush | flush_pend_q) begin
                    state_d = ST_FLUSH;
                end else if (access && hit) begin
                    cpu_rsp.busy = 1'b0;
                    if (cpu_req.wen) begin
                        wr_en         = 1'b1;
                        wr_line.dirty = 1'b1;
                        // merge enabled bytes only
                        for (int b = 0; b < 4; b++) begin
                            if (cpu_req.byte_en[b]) begin
                                wr_line.data[req_a.f.word][8*b +: 8] = cpu_req.wdata[8*b +: 8];
                            end
                        end
                    end
                end else if (access) begin
                    fill_start = 1'b1;
                    state_d    = ST_MISS_WAIT;
                end
            end
            ST_MISS_WAIT: begin
                if (fill_done) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                // request is still held, so its tag names the new line
                wr_en         = 1'b1;
                wr_line.valid = 1'b1;
                wr_line.dirty = 1'b0;
                wr_line.tag   = req_a.f.tag;
                wr_line.data  = fill_line;
                state_d       = ST_LOOKUP;
            end
            ST_FLUSH: begin
                flush_start = 1'b1;
                if (walk_done) begin
                    flush_done = 1'b1;
                    state_d    = ST_LOOKUP;
                end
            end
            default: begin
                state_d = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q      <= ST_INIT;
            flush_pend_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            // keep a flush seen during a miss until the walk starts
            flush_pend_q <= (flush_pend_q | flush) & (state_q != ST_FLUSH);
        end
    end

endmodule

// ==== verilog/cache_line_array.sv ====
/*
 * cache line array
 * N_SETS lines, asynchronous read on the lookup and maintenance ports,
 * one write per cycle where a maintenance clear beats a lookup write
 */
`timescale 1ns/1ps

module cache_line_array (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [l1_cache_pkg::SET_W-1:0] rd_set,
    output l1_cache_pkg::cache_line_t      rd_line,
    input  logic                           wr_en,
    input  l1_cache_pkg::cache_line_t      wr_line,
    input  logic [l1_cache_pkg::SET_W-1:0] maint_set,
    output l1_cache_pkg::cache_line_t      maint_line,
    input  logic                           maint_clear
);

    l1_cache_pkg::cache_line_t lines [l1_cache_pkg::N_SETS];
    // valid bit per line
    logic [l1_cache_pkg::N_SETS-1:0] valid_q;

    always_comb begin
        rd_line          = lines[rd_set];
        rd_line.valid    = valid_q[rd_set];
        maint_line       = lines[maint_set];
        maint_line.valid = valid_q[maint_set];
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (maint_clear) begin
            valid_q[maint_set] <= 1'b0;
        end else if (wr_en) begin
            valid_q[rd_set] <= wr_line.valid;
        end
    end

    // tag, dirty and data
    always_ff @(posedge CLK) begin
        if (maint_clear) begin
            lines[maint_set] <= '0;
        end else if (wr_en) begin
            lines[rd_set] <= wr_line;
        end
    end

endmodule

// ==== verilog/flush_engine.sv ====
/*
 * flush engine
 * walks all sets while flush_start is held; dirty valid lines are written
 * back word by word, then every line is cleared; init mode skips writeback
 */
`timescale 1ns/1ps

module flush_engine (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           flush_start,
    input  logic                           init_mode,
    output logic                           walk_done,
    output logic [l1_cache_pkg::SET_W-1:0] maint_set,
    input  l1_cache_pkg::cache_line_t      maint_line,
    output logic                           maint_clear,
    output l1_cache_pkg::mem_req_t         mem_req,
    output logic                           burst_last,
    input  l1_cache_pkg::mem_rsp_t         mem_rsp
);

    logic [l1_cache_pkg::SET_W-1:0]      set_q;
    logic [l1_cache_pkg::WORD_SEL_W-1:0] word_q;
    logic                                wb;
    logic                                last_word;
    logic                                step_done;
    l1_cache_pkg::cache_addr_u           addr_a;

    assign maint_set = set_q;
    assign last_word = (word_q == l1_cache_pkg::WORD_SEL_W'(l1_cache_pkg::BLOCK_WORDS - 1));

    // this line needs writing back
    assign wb = flush_start && !init_mode && maint_line.valid && maint_line.dirty;

    always_comb begin
        addr_a            = '0;
        addr_a.f.tag      = maint_line.tag;
        addr_a.f.set      = set_q;
        addr_a.f.word     = word_q;
    end

    assign mem_req.ren   = 1'b0;
    assign mem_req.wen   = wb;
    assign mem_req.addr  = addr_a.raw;
    assign mem_req.wdata = maint_line.data[word_q];
    assign burst_last    = wb && last_word;

    // clean lines take one cycle, dirty ones wait for the last word
    assign step_done   = !wb || (!mem_rsp.busy && last_word);
    assign maint_clear = flush_start && step_done;
    assign walk_done   = maint_clear &&
                         (set_q == l1_cache_pkg::SET_W'(l1_cache_pkg::N_SETS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set_q  <= '0;
            word_q <= '0;
        end else if (flush_start) begin
            if (step_done) begin
                // set counter wraps to zero after the last set
                set_q  <= set_q + 1'b1;
                word_q <= '0;
            end else if (!mem_rsp.busy) begin
                word_q <= word_q + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/l1_cache_pkg.sv ====
/*
 * l1 data cache package
 * fixed cache geometry, the address union and the bus and line structs
 * shared by the controller, the line array and both memory engines
 */
package l1_cache_pkg;

    // geometry
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 4;
    localparam int N_SETS      = 16;
    localparam int WORD_SEL_W  = 2;
    localparam int SET_W       = 4;
    localparam int TAG_W       = 24;

    typedef logic [WORD_W-1:0] word_t;
    typedef word_t [BLOCK_WORDS-1:0] line_data_t;

    // field view of a byte address
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [SET_W-1:0]      set;
        logic [WORD_SEL_W-1:0] word;
        logic [1:0]            byte_off;
    } addr_fields_t;

    // same word seen as a bus address or as cache fields
    typedef union packed {
        word_t        raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
        line_data_t       data;
    } cache_line_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    // miss job handed to the fill engine
    typedef struct packed {
        logic       victim_dirty;
        word_t      victim_base;
        line_data_t victim_data;
        word_t      fetch_base;
    } fill_cmd_t;

endpackage

// ==== verilog/l1_cache_top.sv ====
/*
 * l1 data cache top level
 * direct-mapped write-back cache between a cpu word bus and a memory word bus;
 * the fill and flush engines share the memory bus through an arbiter
 */
`timescale 1ns/1ps

module l1_cache_top (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::cpu_req_t cpu_req,
    output l1_cache_pkg::cpu_rsp_t cpu_rsp,
    input  logic                   flush,
    output logic                   flush_done,
    output l1_cache_pkg::mem_req_t mem_req,
    input  l1_cache_pkg::mem_rsp_t mem_rsp
);

    // lookup port
    logic [l1_cache_pkg::SET_W-1:0] rd_set;
    l1_cache_pkg::cache_line_t      rd_line;
    logic                           wr_en;
    l1_cache_pkg::cache_line_t      wr_line;

    // maintenance port
    logic [l1_cache_pkg::SET_W-1:0] maint_set;
    l1_cache_pkg::cache_line_t      maint_line;
    logic                           maint_clear;

    // controller to engines
    logic                       fill_start;
    l1_cache_pkg::fill_cmd_t    fill_cmd;
    logic                       fill_done;
    l1_cache_pkg::line_data_t   fill_line;
    logic                       flush_start;
    logic                       init_mode;
    logic                       walk_done;

    // engines to arbiter
    l1_cache_pkg::mem_req_t fill_req;
    l1_cache_pkg::mem_req_t flush_req;
    l1_cache_pkg::mem_rsp_t fill_rsp;
    l1_cache_pkg::mem_rsp_t flush_rsp;
    logic                   fill_last;
    logic                   flush_last;

    cache_controller ctrl_i (
        .CLK, .nRST, .cpu_req, .cpu_rsp, .flush, .flush_done,
        .rd_set, .rd_line, .wr_en, .wr_line,
        .fill_start, .fill_cmd, .fill_done, .fill_line,
        .flush_start, .init_mode, .walk_done
    );

    cache_line_array array_i (
        .CLK, .nRST, .rd_set, .rd_line, .wr_en, .wr_line,
        .maint_set, .maint_line, .maint_clear
    );

    line_fill_engine fill_i (
        .CLK, .nRST, .fill_start, .fill_cmd, .fill_done, .fill_line,
        .mem_req(fill_req), .burst_last(fill_last), .mem_rsp(fill_rsp)
    );

    flush_engine flush_i (
        .CLK, .nRST, .flush_start, .init_mode, .walk_done,
        .maint_set, .maint_line, .maint_clear,
        .mem_req(flush_req), .burst_last(flush_last), .mem_rsp(flush_rsp)
    );

    mem_bus_arbiter arb_i (
        .CLK, .nRST, .fill_req, .flush_req, .fill_last, .flush_last,
        .fill_rsp, .flush_rsp, .mem_req, .mem_rsp
    );

endmodule

// ==== verilog/line_fill_engine.sv ====
/*
 * line fill engine
 * writes a dirty victim back word by word, then reads the new line
 * from memory into a line register and pulses fill_done
 */
`timescale 1ns/1ps

module line_fill_engine (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     fill_start,
    input  l1_cache_pkg::fill_cmd_t  fill_cmd,
    output logic                     fill_done,
    output l1_cache_pkg::line_data_t fill_line,
    output l1_cache_pkg::mem_req_t   mem_req,
    output logic                     burst_last,
    input  l1_cache_pkg::mem_rsp_t   mem_rsp
);

    typedef enum logic [1:0] {FE_IDLE, FE_WB, FE_FETCH, FE_DONE} fe_state_t;

    fe_state_t                           state_q;
    logic [l1_cache_pkg::WORD_SEL_W-1:0] word_q;
    logic                                last_word;
    l1_cache_pkg::fill_cmd_t             cmd_q;
    l1_cache_pkg::line_data_t            line_q;
    l1_cache_pkg::cache_addr_u           addr_a;

    assign last_word = (word_q == l1_cache_pkg::WORD_SEL_W'(l1_cache_pkg::BLOCK_WORDS - 1));

    // word address inside the victim or the fetched line
    always_comb begin
        addr_a.raw    = (state_q == FE_WB) ? cmd_q.victim_base : cmd_q.fetch_base;
        addr_a.f.word = word_q;
    end

    assign mem_req.wen   = (state_q == FE_WB);
    assign mem_req.ren   = (state_q == FE_FETCH);
    assign mem_req.addr  = addr_a.raw;
    assign mem_req.wdata = cmd_q.victim_data[word_q];
    assign burst_last    = (state_q == FE_FETCH) && last_word;
    assign fill_done     = (state_q == FE_DONE);
    assign fill_line     = line_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= FE_IDLE;
            word_q  <= '0;
        end else begin
            case (state_q)
                FE_IDLE: begin
                    word_q <= '0;
                    if (fill_start) begin
                        state_q <= fill_cmd.victim_dirty ? FE_WB : FE_FETCH;
                    end
                end
                FE_WB, FE_FETCH: begin
                    // advance only on a completed word
                    if (!mem_rsp.busy) begin
                        word_q <= word_q + 1'b1;
                        if (last_word) begin
                            state_q <= (state_q == FE_WB) ? FE_FETCH : FE_DONE;
                        end
                    end
                end
                default: begin
                    state_q <= FE_IDLE;
                end
            endcase
        end
    end

    // job and line payload
    always_ff @(posedge CLK) begin
        if (state_q == FE_IDLE && fill_start) begin
            cmd_q <= fill_cmd;
        end
        if (state_q == FE_FETCH && !mem_rsp.busy) begin
            line_q[word_q] <= mem_rsp.rdata;
        end
    end

endmodule

// ==== verilog/mem_bus_arbiter.sv ====
/*
 * memory bus arbiter
 * flush engine wins a free bus; a grant is held until the owner
 * completes a word marked burst_last
 */
`timescale 1ns/1ps

module mem_bus_arbiter (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::mem_req_t fill_req,
    input  l1_cache_pkg::mem_req_t flush_req,
    input  logic                   fill_last,
    input  logic                   flush_last,
    output l1_cache_pkg::mem_rsp_t fill_rsp,
    output l1_cache_pkg::mem_rsp_t flush_rsp,
    output l1_cache_pkg::mem_req_t mem_req,
    input  l1_cache_pkg::mem_rsp_t mem_rsp
);

    logic locked_q;
    // owner 1 is the flush engine
    logic owner_q;
    logic gnt_flush;
    logic active;
    logic last;

    assign gnt_flush = locked_q ? owner_q : (flush_req.ren | flush_req.wen);
    assign mem_req   = gnt_flush ? flush_req : fill_req;
    assign last      = gnt_flush ? flush_last : fill_last;
    assign active    = mem_req.ren | mem_req.wen;

    // loser sees a busy bus
    always_comb begin
        fill_rsp       = mem_rsp;
        flush_rsp      = mem_rsp;
        fill_rsp.busy  = mem_rsp.busy | gnt_flush;
        flush_rsp.busy = mem_rsp.busy | !gnt_flush;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            locked_q <= 1'b0;
            owner_q  <= 1'b0;
        end else if (active) begin
            locked_q <= !(last && !mem_rsp.busy);
            owner_q  <= gnt_flush;
        end
    end

endmodule
